// File: filelist.f
hdl/histogram_pkg.sv
hdl/bin_mapper.sv
hdl/histogram_core.sv
hdl/histogram_ram.sv
hdl/histogram_readout.sv
hdl/histogram_top.sv
tb/histogram_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run the histogram testbench.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module histogram_tb -f filelist.f -o histogram_sim \
  || { echo "Build failed"; exit 1; }
output=$(./obj_dir/histogram_sim)
echo "$output"
echo "$output" | grep -q "Verification passed" && exit 0 || exit 1

// File: tb/histogram_tb.sv
`default_nettype none

module histogram_tb;

  localparam int SAMPLE_WIDTH = 8;
  localparam int ADDR_WIDTH   = 4;
  localparam int DATA_WIDTH   = 6;
  localparam int BIN_OFFSET   = 16;
  localparam int BIN_SHIFT    = 3;
  localparam int NUM_BINS     = 2 ** ADDR_WIDTH;
  localparam int NUM_TESTS    = 8;
  localparam int TIMEOUT      = 200;

  logic                    clock;
  logic                    aresetn;
  logic                    s_valid;
  logic [SAMPLE_WIDTH-1:0] s_sample;
  logic                    s_ready;
  logic                    m_ready;
  logic [DATA_WIDTH-1:0]   m_data;
  logic                    m_last;

  logic [DATA_WIDTH-1:0] model_bins [NUM_BINS];
  logic [31:0]           lfsr_state;
  int                    errors;
  int                    checks;
  int                    tests;

  // ########################################
  // Stimulus table
  // ########################################

  string      test_name [NUM_TESTS] = '{"bin 0 edge", "bin 5", "bin 14", "clamp low",
                                        "clamp high", "saturation", "ready toggle",
                                        "random stream"};
  logic [7:0] test_sample [NUM_TESTS] = '{8'd16, 8'd56, 8'd135, 8'd7,
                                          8'd250, 8'd100, 8'd200, 8'd0};
  // Bin each fixed sample lands in.
  int         test_bin [NUM_TESTS] = '{0, 5, 14, 0, 15, 10, 15, 0};
  int         test_repeats [NUM_TESTS] = '{3, 2, 4, 5, 3, 70, 1, 100};
  bit         test_random [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  bit         test_toggle [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

  histogram_top #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .ADDR_WIDTH   (ADDR_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH),
    .BIN_OFFSET   (BIN_OFFSET),
    .BIN_SHIFT    (BIN_SHIFT)
  ) uut (
    .clock    (clock),
    .aresetn  (aresetn),
    .s_valid  (s_valid),
    .s_sample (s_sample),
    .s_ready  (s_ready),
    .m_ready  (m_ready),
    .m_data   (m_data),
    .m_last   (m_last)
  );

  always #2 clock = ~clock;

  // ########################################
  // Helpers
  // ########################################

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  function automatic int random_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state); // One step per bit.
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  function automatic int expected_bin(input int sample);
    int index;
    if (sample < BIN_OFFSET)
      return 0;
    index = (sample - BIN_OFFSET) >> BIN_SHIFT;
    return (index > NUM_BINS - 1) ? NUM_BINS - 1 : index; // Clamp to the last bin.
  endfunction

  // Core idle, nothing staged and the mapper empty.
  function automatic bit pipeline_idle();
    return uut.core.state_reg == histogram_pkg::st_idle && !uut.bin_valid && !uut.a_we;
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("error at time %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
  endtask

  task automatic report_test(input string name, input int failures);
    tests++;
    if (failures == 0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, failures);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic reset_dut();
    aresetn = 1'b0;
    s_valid = 1'b0;
    m_ready = 1'b1;
    repeat (4) next_cycle();
    aresetn = 1'b1;
    for (int i = 0; i < NUM_BINS; i++)
      model_bins[i] = '0;
  endtask

  task automatic send_sample(input logic [SAMPLE_WIDTH-1:0] sample, input int bin);
    int waited;
    waited   = 0;
    s_valid  = 1'b1;
    s_sample = sample;
    while (!s_ready && waited < TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (!s_ready)
    begin
      errors++;
      $display("timeout: the DUT never accepted sample %0d", sample);
    end
    else
    begin
      next_cycle(); // Transfer at this edge.
      if (!(&model_bins[bin]))
        model_bins[bin] = model_bins[bin] + 1'b1;
    end
    s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int                         waited;
    histogram_pkg::core_state_t state;
    waited = 0;
    while (!pipeline_idle() && waited < TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (!pipeline_idle())
    begin
      state = uut.core.state_reg;
      errors++;
      $display("timeout: the pipeline did not drain, core still in %s", state.name());
    end
  endtask

  // Align on the highest bin, then read one pass of all bins.
  task automatic check_histogram(input bit toggle);
    int                    waited;
    int                    taken;
    int                    lasts;
    logic                  ready;
    logic                  held;
    logic [DATA_WIDTH-1:0] held_data;
    logic                  held_last;
    waited    = 0;
    taken     = 0;
    lasts     = 0;
    held      = 1'b0;
    held_data = '0;
    held_last = 1'b0;
    m_ready   = 1'b1;
    while (!m_last && waited < TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (!m_last)
    begin
      errors++;
      $display("timeout: m_last never rose on the readout");
    end
    else
    begin
      next_cycle(); // Bin 0 is shown now.
      waited = 0;
      while (taken < NUM_BINS && waited < TIMEOUT)
      begin
        checks++;
        if (held && m_data !== held_data)
          report_mismatch("m_data while held", int'(held_data), int'(m_data));
        if (held && m_last !== held_last)
          report_mismatch("m_last while held", int'(held_last), int'(m_last));
        ready   = toggle ? 1'(random_bits(1)) : 1'b1;
        m_ready = ready;
        if (ready)
        begin
          if (m_data !== model_bins[taken])
            report_mismatch($sformatf("m_data bin %0d", taken), int'(model_bins[taken]),
                            int'(m_data));
          if (m_last !== (taken == NUM_BINS - 1))
            report_mismatch($sformatf("m_last bin %0d", taken), int'(taken == NUM_BINS - 1),
                            int'(m_last));
          if (m_last)
            lasts++;
          taken++;
        end
        held      = !ready;
        held_data = m_data;
        held_last = m_last;
        next_cycle();
        waited++;
      end
      m_ready = 1'b1;
      if (taken < NUM_BINS)
      begin
        errors++;
        $display("timeout: only %0d bins were read out", taken);
      end
      else if (lasts != 1)
      begin
        errors++;
        $display("m_last was seen %0d times in one pass over the bins", lasts);
      end
    end
  endtask

  task automatic run_clear_test(input string name);
    int first;
    first = errors;
    checks++;
    if (s_ready !== 1'b1) // Mapper is empty after reset.
      report_mismatch("s_ready", 1, int'(s_ready));
    wait_drain();
    check_histogram(1'b0);
    report_test(name, errors - first);
  endtask

  // ########################################
  // Main sequence
  // ########################################

  initial
  begin
    int                      first;
    int                      gap;
    logic [SAMPLE_WIDTH-1:0] sample;
    clock      = 1'b0;
    aresetn    = 1'b0;
    s_valid    = 1'b0;
    s_sample   = '0;
    m_ready    = 1'b1;
    lfsr_state = 32'h1cfb;
    errors     = 0;
    checks     = 0;
    tests      = 0;

    reset_dut();
    run_clear_test("clear after reset");

    for (int t = 0; t < NUM_TESTS; t++)
    begin
      first = errors;
      for (int n = 0; n < test_repeats[t]; n++)
      begin
        if (test_random[t])
        begin
          sample = 8'(random_bits(8));
          send_sample(sample, expected_bin(int'(sample)));
          gap = random_bits(2); // Idle cycles between samples.
          repeat (gap) next_cycle();
        end
        else
        begin
          send_sample(test_sample[t], test_bin[t]);
        end
      end
      wait_drain();
      check_histogram(test_toggle[t]);
      report_test(test_name[t], errors - first);
    end

    reset_dut();
    run_clear_test("clear after second reset");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/histogram_top.sv
`default_nettype none

module histogram_top #(
  parameter int SAMPLE_WIDTH = histogram_pkg::sample_width_default,
  parameter int ADDR_WIDTH   = histogram_pkg::addr_width_default,
  parameter int DATA_WIDTH   = histogram_pkg::data_width_default,
  parameter int BIN_OFFSET   = 64,
  parameter int BIN_SHIFT    = 4
) (
  input  wire                     clock,
  input  wire                     aresetn,
  input  wire                     s_valid,
  input  wire  [SAMPLE_WIDTH-1:0] s_sample,
  output logic                    s_ready,
  input  wire                     m_ready,
  output logic [DATA_WIDTH-1:0]   m_data,
  output logic                    m_last
);

  // Mapper to core.
  logic                  bin_valid;
  logic [ADDR_WIDTH-1:0] bin_index;
  logic                  bin_ready;

  // RAM port A.
  logic [ADDR_WIDTH-1:0] a_addr;
  logic                  a_en;
  logic                  a_we;
  logic [DATA_WIDTH-1:0] a_wdata;
  logic [DATA_WIDTH-1:0] a_rdata;

  // RAM port B.
  logic [ADDR_WIDTH-1:0] b_addr;
  logic [DATA_WIDTH-1:0] b_rdata;

  bin_mapper #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH),
    .ADDR_WIDTH   (ADDR_WIDTH),
    .BIN_OFFSET   (BIN_OFFSET),
    .BIN_SHIFT    (BIN_SHIFT)
  ) mapper (
    .clock     (clock),
    .aresetn   (aresetn),
    .s_valid   (s_valid),
    .s_sample  (s_sample),
    .s_ready   (s_ready),
    .bin_valid (bin_valid),
    .bin_index (bin_index),
    .bin_ready (bin_ready)
  );

  histogram_core #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) core (
    .clock     (clock),
    .aresetn   (aresetn),
    .bin_valid (bin_valid),
    .bin_index (bin_index),
    .bin_ready (bin_ready),
    .a_addr    (a_addr),
    .a_en      (a_en),
    .a_we      (a_we),
    .a_wdata   (a_wdata),
    .a_rdata   (a_rdata)
  );

  histogram_ram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) ram (
    .clock   (clock),
    .a_addr  (a_addr),
    .a_en    (a_en),
    .a_we    (a_we),
    .a_wdata (a_wdata),
    .a_rdata (a_rdata),
    .b_addr  (b_addr),
    .b_rdata (b_rdata)
  );

  histogram_readout #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) readout (
    .clock   (clock),
    .aresetn (aresetn),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last),
    .b_addr  (b_addr),
    .b_rdata (b_rdata)
  );

endmodule

`default_nettype wire

// File: hdl/histogram_readout.sv
`default_nettype none

module histogram_readout #(
  parameter int ADDR_WIDTH = histogram_pkg::addr_width_default,
  parameter int DATA_WIDTH = histogram_pkg::data_width_default
) (
  input  wire                   clock,
  input  wire                   aresetn,
  input  wire                   m_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic                  m_last,
  output logic [ADDR_WIDTH-1:0] b_addr,
  input  wire  [DATA_WIDTH-1:0] b_rdata
);

  logic [ADDR_WIDTH-1:0] cntr_reg;
  logic                  last_reg;

  // Bin shown on m_data, steps on every accepted cycle.
  always_ff @(posedge clock)
  begin
    if (!aresetn)
      cntr_reg <= '0;
    else if (m_ready)
      cntr_reg <= cntr_reg + 1'b1;
  end

  // Next bin when the consumer takes this one, else the same bin again.
  assign b_addr = m_ready ? cntr_reg + 1'b1 : cntr_reg;

  // Follows the RAM read by one cycle so it lines up with b_rdata.
  always_ff @(posedge clock)
  begin
    if (!aresetn)
      last_reg <= 1'b0;
    else
      last_reg <= &b_addr;
  end

  assign m_data = b_rdata;
  assign m_last = last_reg;

endmodule

`default_nettype wire

// File: hdl/histogram_ram.sv
`default_nettype none

module histogram_ram #(
  parameter int ADDR_WIDTH = histogram_pkg::addr_width_default,
  parameter int DATA_WIDTH = histogram_pkg::data_width_default
) (
  input  wire                   clock,
  input  wire  [ADDR_WIDTH-1:0] a_addr,
  input  wire                   a_en,
  input  wire                   a_we,
  input  wire  [DATA_WIDTH-1:0] a_wdata,
  output logic [DATA_WIDTH-1:0] a_rdata,
  input  wire  [ADDR_WIDTH-1:0] b_addr,
  output logic [DATA_WIDTH-1:0] b_rdata
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // ########################################
  // Port A, read first
  // ########################################

  always_ff @(posedge clock)
  begin
    if (a_en)
    begin
      if (a_we)
        mem[a_addr] <= a_wdata;
      a_rdata <= mem[a_addr]; // Old contents on a write.
    end
  end

  // ########################################
  // Port B, read only
  // ########################################

  always_ff @(posedge clock)
  begin
    b_rdata <= mem[b_addr];
  end

endmodule

`default_nettype wire

// File: hdl/histogram_core.sv
`default_nettype none

module histogram_core #(
  parameter int ADDR_WIDTH = histogram_pkg::addr_width_default,
  parameter int DATA_WIDTH = histogram_pkg::data_width_default
) (
  input  wire                   clock,
  input  wire                   aresetn,
  input  wire                   bin_valid,
  input  wire  [ADDR_WIDTH-1:0] bin_index,
  output logic                  bin_ready,
  output logic [ADDR_WIDTH-1:0] a_addr,
  output logic                  a_en,
  output logic                  a_we,
  output logic [DATA_WIDTH-1:0] a_wdata,
  input  wire  [DATA_WIDTH-1:0] a_rdata
);

  histogram_pkg::core_state_t state_reg, state_next;

  logic [ADDR_WIDTH-1:0] addr_reg, addr_next;
  logic [DATA_WIDTH-1:0] data_reg, data_next;
  logic                  en_reg, en_next;
  logic                  we_reg, we_next;
  logic                  ready_reg, ready_next;

  // ########################################
  // Registers
  // ########################################

  always_ff @(posedge clock)
  begin
    if (!aresetn)
    begin
      state_reg <= histogram_pkg::st_clear;
      addr_reg  <= '0;
      data_reg  <= '0; // Zero is what the clear writes.
      en_reg    <= 1'b1;
      we_reg    <= 1'b1;
      ready_reg <= 1'b0;
    end
    else
    begin
      state_reg <= state_next;
      addr_reg  <= addr_next;
      data_reg  <= data_next;
      en_reg    <= en_next;
      we_reg    <= we_next;
      ready_reg <= ready_next;
    end
  end

  // ########################################
  // Next state
  // ########################################

  always_comb
  begin
    state_next = state_reg;
    addr_next  = addr_reg;
    data_next  = data_reg;
    en_next    = en_reg;
    we_next    = we_reg;
    ready_next = ready_reg;

    case (state_reg)
      histogram_pkg::st_clear:
      begin
        addr_next = addr_reg + 1'b1; // One bin per cycle.
        if (&addr_reg)
        begin
          en_next    = 1'b0;
          we_next    = 1'b0;
          ready_next = 1'b1;
          state_next = histogram_pkg::st_idle;
        end
      end

      histogram_pkg::st_idle:
      begin
        // The write staged in st_update commits during this cycle.
        en_next = 1'b0;
        we_next = 1'b0;
        if (bin_valid && ready_reg)
        begin
          addr_next  = bin_index;
          en_next    = 1'b1;
          ready_next = 1'b0;
          state_next = histogram_pkg::st_read;
        end
      end

      histogram_pkg::st_read:
      begin
        state_next = histogram_pkg::st_update;
      end

      histogram_pkg::st_update:
      begin
        we_next    = 1'b1;
        data_next  = (&a_rdata) ? a_rdata : a_rdata + 1'b1; // Saturate at all ones.
        ready_next = 1'b1;
        state_next = histogram_pkg::st_idle;
      end

      default:
      begin
        state_next = histogram_pkg::st_clear;
      end
    endcase
  end

  assign bin_ready = ready_reg;
  assign a_addr    = addr_reg;
  assign a_en      = en_reg;
  assign a_we      = we_reg;
  assign a_wdata   = data_reg;

endmodule

`default_nettype wire

// File: hdl/bin_mapper.sv
`default_nettype none

module bin_mapper #(
  parameter int SAMPLE_WIDTH = histogram_pkg::sample_width_default,
  parameter int ADDR_WIDTH   = histogram_pkg::addr_width_default,
  parameter int BIN_OFFSET   = 0,
  parameter int BIN_SHIFT    = 4
) (
  input  wire                     clock,
  input  wire                     aresetn,
  input  wire                     s_valid,
  input  wire  [SAMPLE_WIDTH-1:0] s_sample,
  output logic                    s_ready,
  output logic                    bin_valid,
  output logic [ADDR_WIDTH-1:0]   bin_index,
  input  wire                     bin_ready
);

  localparam logic [SAMPLE_WIDTH-1:0] OFFSET   = SAMPLE_WIDTH'(BIN_OFFSET);
  localparam logic [SAMPLE_WIDTH-1:0] LAST_BIN = SAMPLE_WIDTH'((2 ** ADDR_WIDTH) - 1);

  logic [SAMPLE_WIDTH-1:0] shifted;
  logic [ADDR_WIDTH-1:0]   mapped;
  logic [ADDR_WIDTH-1:0]   index_reg;
  logic                    full_reg;

  // Offset, shift and clamp.
  always_comb
  begin
    shifted = (s_sample - OFFSET) >> BIN_SHIFT;
    if (s_sample < OFFSET)
      mapped = '0; // Underflow goes to the first bin.
    else if (shifted > LAST_BIN)
      mapped = '1; // Overflow goes to the last bin.
    else
      mapped = shifted[ADDR_WIDTH-1:0];
  end

  always_ff @(posedge clock)
  begin
    if (!aresetn)
    begin
      full_reg <= 1'b0;
    end
    else if (s_valid && s_ready)
    begin
      full_reg <= 1'b1;
    end
    else if (bin_ready)
    begin
      full_reg <= 1'b0; // Core took the item.
    end
  end

  always_ff @(posedge clock)
  begin
    if (s_valid && s_ready)
      index_reg <= mapped;
  end

  assign s_ready   = !full_reg || bin_ready;
  assign bin_valid = full_reg;
  assign bin_index = index_reg;

endmodule

`default_nettype wire

// File: hdl/histogram_pkg.sv
`default_nettype none

package histogram_pkg;

  // ########################################
  // Default widths
  // ########################################

  // Input sample width.
  localparam int sample_width_default = 12;

  // Bin index width, 2**8 bins by default.
  localparam int addr_width_default = 8;

  // Count held in each bin.
  localparam int data_width_default = 16;

  // ########################################
  // Core states
  // ########################################

  typedef enum logic [1:0] {
    st_clear  = 2'd0, // Zero fill after reset.
    st_idle   = 2'd1, // Waiting for a bin index.
    st_read   = 2'd2, // RAM read in flight.
    st_update = 2'd3  // Count is on a_rdata, stage the write.
  } core_state_t;

endpackage

`default_nettype wire
